/* files.f */
rtl/eth_types_pkg.sv
rtl/rx_ctrl_pkg.sv
rtl/rx_preamble_detect.sv
rtl/rx_frame_fsm.sv
rtl/rx_field_check.sv
rtl/udp_rx.sv
verif/tb_udp_rx.sv
+incdir+include

/* run_sim.sh */
#!/bin/sh
# build the udp receive parser testbench with verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps -f files.f --top-module tb_udp_rx \
    -Mdir obj_dir || { echo "verilator build failed"; exit 1; }

./obj_dir/Vtb_udp_rx > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log

grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "no result line in sim.log"; exit 1; }
echo "simulation passed"

/* verif/udp_rx_stimulus.txt */
# columns: dst_mac ethertype ihl proto dst_ip dst_port (hex), payload_len trunc accept (decimal)
# trunc is the number of frame bytes sent after the sfd, 0 sends the whole frame with fcs
001122334455 0800 5 11 c0a8010a 04d2 18 0 1
001122334455 0800 5 11 c0a8010a 04d2 1 0 1
ffffffffffff 0800 5 11 c0a8010a 04d2 30 0 1
001122334455 0800 6 11 c0a8010a 04d2 22 0 1
001122334456 0800 5 11 c0a8010a 04d2 16 0 0
101122334455 0800 5 11 c0a8010a 04d2 16 0 0
ffffffffff00 0800 5 11 c0a8010a 04d2 16 0 0
001122334455 0806 5 11 c0a8010a 04d2 16 0 0
001122334455 0800 5 01 c0a8010a 04d2 16 0 0
001122334455 0800 5 06 c0a8010a 04d2 16 0 0
001122334455 0800 5 11 c0a8010b 04d2 16 0 0
001122334455 0800 5 11 0aa8010a 04d2 16 0 0
001122334455 0800 5 11 c0a8010a 04d3 16 0 0
001122334455 0800 5 11 c0a8010a 14d2 16 0 0
001122334455 0800 5 11 c0a8010a 04d2 40 52 1
001122334455 0800 5 11 c0a8010a 04d2 16 0 1
001122334455 0800 5 11 c0a8010a 04d2 8 52 1
001122334455 0800 5 11 c0a8010a 04d2 12 0 1
001122334455 0800 5 11 c0a8010a 04d2 20 20 1
001122334455 0800 5 11 c0a8010a 04d2 0 0 1
ffffffffffff 0800 7 11 c0a8010a 04d2 5 0 1
001122334466 0800 5 11 c0a8010a 04d2 30 45 0
001122334455 0800 f 11 c0a8010a 04d2 10 0 1
001122334455 0800 5 11 c0a8010a 04d2 64 0 1
01005e000001 0800 5 11 c0a8010a 04d2 12 0 0
001122334455 0800 6 11 c0a8010a 04d2 9 0 1

/* verif/tb_udp_rx.sv */
// Testbench for the UDP/IPv4 receive parser
// builds GMII frames from the stimulus file, checks payload bytes,
// rx_data_length and the rx_done pulse of every frame

`timescale 1ns/1ps

`include "udp_rx_config.svh"

module tb_udp_rx;

    localparam string STIM_FILE    = "verif/udp_rx_stimulus.txt";
    localparam int    SEED         = 63861;
    localparam int    GAP_CYCLES   = 12;
    localparam int    DONE_LATENCY = 2;      // last fcs byte on gmii_rxd to rx_done
    localparam int    DONE_TIMEOUT = 16;

    logic                    clk;
    logic                    rst_n;
    logic                    gmii_rx_dv;
    eth_types_pkg::byte_t    gmii_rxd;
    eth_types_pkg::byte_t    rx_data;
    logic                    rx_data_vld;
    logic                    rx_done;
    eth_types_pkg::length_t  rx_data_length;

    eth_types_pkg::byte_t    frame_q[$];      // frame bytes after the sfd
    eth_types_pkg::byte_t    exp_q[$];        // payload bytes still due on rx_data
    eth_types_pkg::byte_t    exp_byte;
    eth_types_pkg::length_t  exp_len;
    int                      err_cnt;
    int                      done_cnt;
    int                      done_exp;
    int                      frame_cnt;
    int                      byte_seen;

    // fields of the current stimulus line
    eth_types_pkg::mac_addr_t   dst_mac;
    eth_types_pkg::ethertype_t  eth_type;
    logic [7:0]                 proto;
    eth_types_pkg::ip_addr_t    dst_ip;
    eth_types_pkg::udp_port_t   dst_port;
    int                         ihl;
    int                         pay_len;
    int                         trunc;        // bytes sent after the sfd, 0 for all
    int                         accept;

    udp_rx i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .gmii_rx_dv     (gmii_rx_dv),
        .gmii_rxd       (gmii_rxd),
        .rx_data        (rx_data),
        .rx_data_vld    (rx_data_vld),
        .rx_done        (rx_done),
        .rx_data_length (rx_data_length)
    );

    always #2 clk = ~clk;  // 4 ns period

    function automatic eth_types_pkg::byte_t rand_byte();
        logic [31:0] r;
        r = $urandom();
        return r[7:0];
    endfunction

    task automatic push_rand(input int n);
        for (int i = 0; i < n; i++) begin
            frame_q.push_back(rand_byte());
        end
    endtask

    task automatic push_word(input logic [15:0] w);
        frame_q.push_back(w[15:8]);  // network byte order
        frame_q.push_back(w[7:0]);
    endtask

    task automatic build_frame();
        int                    total_len;
        int                    hdr_len;
        eth_types_pkg::byte_t  b;
        total_len = ihl * 4 + int'(`UDP_RX_UDP_HDR_LEN) + pay_len;
        hdr_len   = int'(`UDP_RX_ETH_HDR_LEN) + ihl * 4 + int'(`UDP_RX_UDP_HDR_LEN);
        frame_q.delete();
        push_word(dst_mac[47:32]);
        push_word(dst_mac[31:16]);
        push_word(dst_mac[15:0]);
        push_rand(6);                        // source mac
        push_word(eth_type);
        frame_q.push_back({4'h4, ihl[3:0]});
        frame_q.push_back(8'h00);            // tos
        push_word(total_len[15:0]);
        push_rand(2);                        // identification
        push_word(16'h4000);                 // df set, no fragment offset
        frame_q.push_back(8'd64);            // ttl
        frame_q.push_back(proto);
        push_rand(6);                        // header checksum and source ip
        push_word(dst_ip[31:16]);
        push_word(dst_ip[15:0]);
        push_rand((ihl - 5) * 4);            // ip options
        push_rand(2);                        // source port
        push_word(dst_port);
        push_word(pay_len[15:0] + 16'd8);    // udp length
        push_rand(2);                        // udp checksum
        for (int i = 0; i < pay_len; i++) begin
            b = rand_byte();
            frame_q.push_back(b);
            // only bytes ahead of a dv drop reach rx_data
            if (accept != 0 && (trunc == 0 || hdr_len + i < trunc)) begin
                exp_q.push_back(b);
            end
        end
        push_rand(int'(`UDP_RX_FCS_LEN));
    endtask

    task automatic drive_frame();
        int n;
        n = (trunc == 0 || trunc > frame_q.size()) ? frame_q.size() : trunc;
        for (int i = 0; i < `UDP_RX_PREAMBLE_LEN + 1; i++) begin
            @(posedge clk);
            gmii_rx_dv <= 1'b1;
            gmii_rxd   <= (i < `UDP_RX_PREAMBLE_LEN) ? `UDP_RX_PREAMBLE_BYTE : `UDP_RX_SFD_BYTE;
        end
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            gmii_rxd <= frame_q[i];
        end
        @(posedge clk);
        gmii_rx_dv <= 1'b0;
        gmii_rxd   <= 8'h00;
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        while (rx_done !== 1'b1 && waited < DONE_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (rx_done !== 1'b1) begin
            $display("timeout: frame %0d gave no rx_done within %0d cycles",
                     frame_cnt, DONE_TIMEOUT);
            err_cnt++;
        end else if (waited != DONE_LATENCY) begin
            $display("frame %0d: rx_done came %0d cycles after the last fcs byte, expected %0d",
                     frame_cnt, waited, DONE_LATENCY);
            err_cnt++;
        end
    endtask

    task automatic run_frame();
        frame_cnt++;
        exp_len = pay_len[15:0];
        build_frame();
        drive_frame();
        if (accept != 0 && trunc == 0) begin
            done_exp++;
            wait_done();
        end
        repeat (GAP_CYCLES) @(posedge clk);  // idle gap with dv low
        if (done_cnt != done_exp) begin
            $display("frame %0d: %0d rx_done pulses so far, expected %0d",
                     frame_cnt, done_cnt, done_exp);
            err_cnt++;
            done_exp = done_cnt;
        end
        if (exp_q.size() != 0) begin
            $display("frame %0d: %0d payload bytes never appeared on rx_data",
                     frame_cnt, exp_q.size());
            err_cnt++;
            exp_q.delete();
        end
    endtask

    // outputs compared mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (rst_n && rx_data_vld === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("payload byte %02h on rx_data at %0t with none expected", rx_data, $time);
                err_cnt++;
            end else begin
                exp_byte = exp_q.pop_front();
                byte_seen++;
                if (rx_data !== exp_byte) begin
                    $display("ERROR at %0t: rx_data expected %02h got %02h",
                             $time, exp_byte, rx_data);
                    err_cnt++;
                end
                if (rx_data_length !== exp_len) begin
                    $display("ERROR at %0t: rx_data_length expected %0d got %0d",
                             $time, exp_len, rx_data_length);
                    err_cnt++;
                end
            end
        end
        if (rst_n && rx_done === 1'b1) begin
            done_cnt++;
            if (exp_q.size() != 0) begin
                $display("rx_done at %0t with %0d payload bytes still missing", $time, exp_q.size());
                err_cnt++;
            end
            if (rx_data_length !== exp_len) begin
                $display("ERROR at %0t: rx_data_length expected %0d got %0d",
                         $time, exp_len, rx_data_length);
                err_cnt++;
            end
        end
    end

    initial begin
        int    fd;
        int    code;
        int    n;
        string line;
        clk        = 1'b0;
        rst_n      = 1'b0;
        gmii_rx_dv = 1'b0;
        gmii_rxd   = 8'h00;
        err_cnt    = 0;
        done_cnt   = 0;
        done_exp   = 0;
        frame_cnt  = 0;
        byte_seen  = 0;
        exp_len    = '0;
        void'($urandom(SEED));
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // quiet outputs before the first frame
        repeat (4) begin
            @(negedge clk);
            if (rx_data_vld !== 1'b0 || rx_done !== 1'b0) begin
                $display("rx_data_vld or rx_done active at %0t before any frame", $time);
                err_cnt++;
            end
        end

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", STIM_FILE);
            err_cnt++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %d %d %d", dst_mac, eth_type, ihl,
                                proto, dst_ip, dst_port, pay_len, trunc, accept);
                    if (n == 9) begin
                        run_frame();
                    end else begin
                        $display("malformed stimulus line: %s", line);
                        err_cnt++;
                    end
                end
            end
            $fclose(fd);
        end

        if (frame_cnt == 0) begin
            $display("no frames were run");
            err_cnt++;
        end
        $display("frames %0d, payload bytes checked %0d, rx_done pulses %0d, errors %0d",
                 frame_cnt, byte_seen, done_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* rtl/udp_rx.sv */
// UDP/IPv4 receive parser top
// takes a GMII byte stream and delivers UDP payload bytes for the
// board's MAC, IP and port, with a done pulse at end of frame

`timescale 1ns/1ps

module udp_rx (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    gmii_rx_dv,
    input  eth_types_pkg::byte_t    gmii_rxd,
    output eth_types_pkg::byte_t    rx_data,
    output logic                    rx_data_vld,
    output logic                    rx_done,
    output eth_types_pkg::length_t  rx_data_length
);

    logic                    sof;
    logic                    hunt;
    logic                    rx_byte_vld;
    eth_types_pkg::byte_t    rx_byte;
    rx_ctrl_pkg::rx_state_t  state;
    rx_ctrl_pkg::byte_cnt_t  byte_cnt;
    logic                    hdr_error;
    eth_types_pkg::length_t  ip_hdr_len;
    eth_types_pkg::length_t  payload_len;

    rx_preamble_detect i_preamble_detect (
        .clk         (clk),
        .rst_n       (rst_n),
        .gmii_rx_dv  (gmii_rx_dv),
        .gmii_rxd    (gmii_rxd),
        .hunt        (hunt),
        .sof         (sof),
        .rx_byte_vld (rx_byte_vld),
        .rx_byte     (rx_byte)
    );

    rx_frame_fsm i_frame_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .sof         (sof),
        .rx_byte_vld (rx_byte_vld),
        .rx_byte     (rx_byte),
        .hdr_error   (hdr_error),
        .ip_hdr_len  (ip_hdr_len),
        .payload_len (payload_len),
        .state       (state),
        .byte_cnt    (byte_cnt),
        .hunt        (hunt),
        .rx_data     (rx_data),
        .rx_data_vld (rx_data_vld),
        .rx_done     (rx_done)
    );

    rx_field_check i_field_check (
        .clk            (clk),
        .rst_n          (rst_n),
        .sof            (sof),
        .rx_byte_vld    (rx_byte_vld),
        .rx_byte        (rx_byte),
        .state          (state),
        .byte_cnt       (byte_cnt),
        .hdr_error      (hdr_error),
        .ip_hdr_len     (ip_hdr_len),
        .payload_len    (payload_len),
        .rx_data_length (rx_data_length)
    );

endmodule

/* rtl/rx_field_check.sv */
// Header field capture and filter
// checks mac, ethertype, ip protocol, ip address and udp port against
// the board, and derives ip header and payload lengths

`timescale 1ns/1ps

`include "udp_rx_config.svh"

module rx_field_check (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    sof,
    input  logic                    rx_byte_vld,
    input  eth_types_pkg::byte_t    rx_byte,
    input  rx_ctrl_pkg::rx_state_t  state,
    input  rx_ctrl_pkg::byte_cnt_t  byte_cnt,
    output logic                    hdr_error,
    output eth_types_pkg::length_t  ip_hdr_len,
    output eth_types_pkg::length_t  payload_len,
    output eth_types_pkg::length_t  rx_data_length
);

    logic [39:0]                 hdr_sr;      // previous five header bytes
    eth_types_pkg::mac_addr_t    dst_mac;
    eth_types_pkg::ethertype_t   eth_type;
    eth_types_pkg::ip_addr_t     dst_ip;
    eth_types_pkg::udp_port_t    dst_port;
    eth_types_pkg::length_t      total_len;
    logic                        field_fail;

    always_ff @(posedge clk) begin
        if (rx_byte_vld) begin
            hdr_sr <= {hdr_sr[31:0], rx_byte};
        end
    end

    // fields as seen on their last byte
    assign dst_mac  = {hdr_sr, rx_byte};
    assign eth_type = {hdr_sr[7:0], rx_byte};
    assign dst_ip   = {hdr_sr[23:0], rx_byte};
    assign dst_port = {hdr_sr[7:0], rx_byte};

    always_comb begin
        field_fail = 1'b0;
        if (rx_byte_vld) begin
            case (state)
                rx_ctrl_pkg::ETH_HDR: begin
                    if (byte_cnt == 16'd5)
                        field_fail = (dst_mac != `UDP_RX_BOARD_MAC) && (dst_mac != '1);
                    else if (byte_cnt == 16'd13)
                        field_fail = (eth_type != `UDP_RX_ETHERTYPE_IPV4);  // arp lands here
                end
                rx_ctrl_pkg::IP_HDR: begin
                    if (byte_cnt == 16'd0)
                        field_fail = (rx_byte[3:0] < 4'd5);  // ihl below minimum header
                    else if (byte_cnt == 16'd9)
                        field_fail = (rx_byte != `UDP_RX_PROTO_UDP);
                    else if (byte_cnt == 16'd19)
                        field_fail = (dst_ip != `UDP_RX_BOARD_IP);
                end
                rx_ctrl_pkg::UDP_HDR: begin
                    if (byte_cnt == 16'd3)
                        field_fail = (dst_port != `UDP_RX_BOARD_PORT);
                end
                default: field_fail = 1'b0;
            endcase
        end
    end

    // sticky until the next frame starts
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hdr_error <= 1'b0;
        end else if (sof) begin
            hdr_error <= 1'b0;
        end else if (field_fail) begin
            hdr_error <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ip_hdr_len  <= 16'd20;
            total_len   <= '0;
            payload_len <= '0;
        end else if (rx_byte_vld && state == rx_ctrl_pkg::IP_HDR) begin
            case (byte_cnt)
                16'd0:   ip_hdr_len  <= {10'd0, rx_byte[3:0], 2'b00};
                16'd3:   total_len   <= {hdr_sr[7:0], rx_byte};
                16'd4:   payload_len <= total_len - ip_hdr_len - `UDP_RX_UDP_HDR_LEN;
                default: total_len   <= total_len;
            endcase
        end
    end

    assign rx_data_length = payload_len;

endmodule

/* rtl/rx_frame_fsm.sv */
// Frame section state machine
// walks ethernet, ip, udp headers, payload and fcs with one byte counter
// and registers the payload bytes and the end-of-frame pulse

`timescale 1ns/1ps

`include "udp_rx_config.svh"

module rx_frame_fsm (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       sof,
    input  logic                       rx_byte_vld,
    input  eth_types_pkg::byte_t       rx_byte,
    input  logic                       hdr_error,
    input  eth_types_pkg::length_t     ip_hdr_len,
    input  eth_types_pkg::length_t     payload_len,
    output rx_ctrl_pkg::rx_state_t     state,
    output rx_ctrl_pkg::byte_cnt_t     byte_cnt,
    output logic                       hunt,
    output eth_types_pkg::byte_t       rx_data,
    output logic                       rx_data_vld,
    output logic                       rx_done
);

    rx_ctrl_pkg::rx_state_t  state_nxt;
    eth_types_pkg::length_t  sect_len;   // bytes in the current section
    logic                    cnt_en;
    logic                    cnt_last;

    assign cnt_en   = rx_byte_vld && (state != rx_ctrl_pkg::HUNT)
                      && (state != rx_ctrl_pkg::DROP);
    assign cnt_last = cnt_en && (byte_cnt == sect_len - 16'd1);
    assign hunt     = (state == rx_ctrl_pkg::HUNT);

    always_comb begin
        case (state)
            rx_ctrl_pkg::ETH_HDR: sect_len = `UDP_RX_ETH_HDR_LEN;
            rx_ctrl_pkg::IP_HDR:  sect_len = ip_hdr_len;   // ihl * 4
            rx_ctrl_pkg::UDP_HDR: sect_len = `UDP_RX_UDP_HDR_LEN;
            rx_ctrl_pkg::PAYLOAD: sect_len = payload_len;
            default:              sect_len = `UDP_RX_FCS_LEN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            byte_cnt <= '0;
        end else if (cnt_last || !cnt_en) begin
            byte_cnt <= '0;
        end else begin
            byte_cnt <= byte_cnt + 16'd1;
        end
    end

    always_comb begin
        state_nxt = state;
        if (state != rx_ctrl_pkg::HUNT && !rx_byte_vld) begin
            state_nxt = rx_ctrl_pkg::HUNT;  // dv dropped mid-frame, no done
        end else begin
            case (state)
                rx_ctrl_pkg::HUNT: begin
                    if (sof) state_nxt = rx_ctrl_pkg::ETH_HDR;
                end
                rx_ctrl_pkg::ETH_HDR: begin
                    if (hdr_error)     state_nxt = rx_ctrl_pkg::DROP;
                    else if (cnt_last) state_nxt = rx_ctrl_pkg::IP_HDR;
                end
                rx_ctrl_pkg::IP_HDR: begin
                    if (hdr_error)     state_nxt = rx_ctrl_pkg::DROP;
                    else if (cnt_last) state_nxt = rx_ctrl_pkg::UDP_HDR;
                end
                rx_ctrl_pkg::UDP_HDR: begin
                    if (hdr_error) begin
                        state_nxt = rx_ctrl_pkg::DROP;
                    end else if (cnt_last) begin
                        // empty datagram skips straight to the fcs
                        state_nxt = (payload_len == 16'd0) ? rx_ctrl_pkg::FCS
                                                           : rx_ctrl_pkg::PAYLOAD;
                    end
                end
                rx_ctrl_pkg::PAYLOAD: begin
                    if (cnt_last) state_nxt = rx_ctrl_pkg::FCS;
                end
                rx_ctrl_pkg::FCS: begin
                    if (cnt_last) state_nxt = rx_ctrl_pkg::DROP;
                end
                rx_ctrl_pkg::DROP: state_nxt = rx_ctrl_pkg::DROP;  // left on dv low above
                default:           state_nxt = rx_ctrl_pkg::HUNT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= rx_ctrl_pkg::HUNT;
            rx_data_vld <= 1'b0;
            rx_done     <= 1'b0;
        end else begin
            state       <= state_nxt;
            rx_data_vld <= (state == rx_ctrl_pkg::PAYLOAD) && rx_byte_vld;
            rx_done     <= (state == rx_ctrl_pkg::FCS) && cnt_last;
        end
    end

    always_ff @(posedge clk) begin
        if (state == rx_ctrl_pkg::PAYLOAD) begin
            rx_data <= rx_byte;
        end
    end

endmodule

/* rtl/rx_preamble_detect.sv */
// GMII preamble and start delimiter detector
// finds seven preamble bytes plus sfd while the parser hunts,
// and passes the byte stream on one cycle late

`timescale 1ns/1ps

`include "udp_rx_config.svh"

module rx_preamble_detect (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 gmii_rx_dv,
    input  eth_types_pkg::byte_t gmii_rxd,
    input  logic                 hunt,
    output logic                 sof,
    output logic                 rx_byte_vld,
    output eth_types_pkg::byte_t rx_byte
);

    eth_types_pkg::byte_t             rxd_sr [`UDP_RX_PREAMBLE_LEN];  // [0] is newest
    logic [`UDP_RX_PREAMBLE_LEN-1:0]  dv_sr;
    logic                             pattern_hit;

    always_ff @(posedge clk) begin
        rxd_sr[0] <= gmii_rxd;
        for (int i = 1; i < `UDP_RX_PREAMBLE_LEN; i++) begin
            rxd_sr[i] <= rxd_sr[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dv_sr <= '0;
        end else begin
            dv_sr <= {dv_sr[`UDP_RX_PREAMBLE_LEN-2:0], gmii_rx_dv};
        end
    end

    // sfd on the input now, preamble bytes behind it, dv high throughout
    always_comb begin
        pattern_hit = gmii_rx_dv && (gmii_rxd == `UDP_RX_SFD_BYTE) && (&dv_sr);
        for (int i = 0; i < `UDP_RX_PREAMBLE_LEN; i++) begin
            if (rxd_sr[i] != `UDP_RX_PREAMBLE_BYTE) begin
                pattern_hit = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sof <= 1'b0;
        end else begin
            sof <= hunt && pattern_hit;  // lines up with sfd on rx_byte
        end
    end

    assign rx_byte     = rxd_sr[0];
    assign rx_byte_vld = dv_sr[0];

endmodule

/* rtl/rx_ctrl_pkg.sv */
// Receive parser control types
// frame section states and the in-section byte position

package rx_ctrl_pkg;

    typedef enum logic [2:0] {
        HUNT,       // waiting for preamble and sfd
        ETH_HDR,
        IP_HDR,
        UDP_HDR,
        PAYLOAD,
        FCS,
        DROP        // rest of frame ignored until dv falls
    } rx_state_t;

    typedef logic [15:0] byte_cnt_t;

endpackage

/* rtl/eth_types_pkg.sv */
// Ethernet/IPv4/UDP field types
// plain vectors sized to the protocol fields the parser handles

package eth_types_pkg;

    // one GMII data byte
    typedef logic [7:0]  byte_t;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] ethertype_t;
    typedef logic [15:0] udp_port_t;

    // byte count of a header, payload or fcs section
    typedef logic [15:0] length_t;

endpackage

/* include/udp_rx_config.svh */
// UDP receive parser configuration
// board addresses, header lengths and protocol constants
// shared by the parser blocks and the testbench

`ifndef UDP_RX_CONFIG_SVH
`define UDP_RX_CONFIG_SVH

`define UDP_RX_BOARD_MAC      48'h00_11_22_33_44_55   // 00-11-22-33-44-55
`define UDP_RX_BOARD_IP       32'hC0_A8_01_0A         // 192.168.1.10
`define UDP_RX_BOARD_PORT     16'd1234

`define UDP_RX_ETH_HDR_LEN    16'd14                  // dst mac, src mac, ethertype
`define UDP_RX_UDP_HDR_LEN    16'd8
`define UDP_RX_FCS_LEN        16'd4

`define UDP_RX_PREAMBLE_BYTE  8'h55
`define UDP_RX_SFD_BYTE       8'hD5
`define UDP_RX_PREAMBLE_LEN   7                       // preamble bytes ahead of sfd

`define UDP_RX_ETHERTYPE_IPV4 16'h0800
`define UDP_RX_PROTO_UDP      8'd17

`endif
